// ==== hdl/fpu_types.sv ====
// shared formats, constants and structs of the floating-point misc unit
// compile this package first; the other files refer to it by scoped names

`default_nettype none

package fpu_types;

    localparam logic [1:0] fmt_single = 2'd0;
    localparam logic [1:0] fmt_double = 2'd1;

    // extended format is 1 sign, 12 exponent and 52 fraction bits
    localparam int unsigned ext_bias          = 2047;
    localparam logic [11:0] ext_exp_ones      = 12'hfff;
    localparam logic [11:0] single_exp_offset = 12'(ext_bias - 127);
    localparam logic [11:0] double_exp_offset = 12'(ext_bias - 1023);

    localparam int unsigned class_neg_inf       = 0;
    localparam int unsigned class_neg_normal    = 1;
    localparam int unsigned class_neg_subnormal = 2;
    localparam int unsigned class_neg_zero      = 3;
    localparam int unsigned class_pos_zero      = 4;
    localparam int unsigned class_pos_subnormal = 5;
    localparam int unsigned class_pos_normal    = 6;
    localparam int unsigned class_pos_inf       = 7;
    localparam int unsigned class_snan          = 8;
    localparam int unsigned class_qnan          = 9;

    localparam logic [63:0] canon_nan_single = 64'hffff_ffff_7fc0_0000;
    localparam logic [63:0] canon_nan_double = 64'h7ff8_0000_0000_0000;

    typedef enum logic [2:0] {
        op_fclass,
        op_feq,
        op_flt,
        op_fle,
        op_fmin,
        op_fmax
    } fpu_op_type;

    typedef struct packed {
        logic [63:0] data;
        logic [1:0]  fmt;
    } fpu_ext_in_type;

    typedef struct packed {
        logic [64:0] result;
        logic [9:0]  classification;
    } fpu_ext_out_type;

    typedef struct packed {
        fpu_op_type  op;
        logic [1:0]  fmt;
        logic [63:0] a;
        logic [63:0] b;
    } fpu_req_type;

    typedef struct packed {
        logic [63:0] result;
        logic        invalid;
    } fpu_rsp_type;

    typedef struct packed {
        fpu_ext_out_type ext;
        logic [63:0]     raw;    // min and max hand back the operand as it came in
    } fpu_operand_type;

endpackage

`default_nettype wire

// ==== hdl/lzc_64.sv ====
// 64-bit leading-zero counter, combinational
// eight byte groups are counted first and the first nonzero group is picked after that

`timescale 1ns/1ns
`default_nettype none

module lzc_64 (
    input  wire  [63:0] data_in,
    output logic [5:0]  lzc,
    output logic        valid
);

    logic [7:0] grp_nz;         // bit 7 is the most significant byte
    logic [2:0] grp_cnt [0:7];  // index 0 is the most significant byte
    logic [2:0] grp_sel;

    // zeros above the highest set bit of one byte
    function automatic logic [2:0] lzc8(input logic [7:0] v);
        logic [2:0] n;
        n = 3'd7;
        for (int i = 0; i < 8; i++) begin
            if (v[i]) n = 3'(7 - i);  // highest set bit wins as the loop climbs
        end
        return n;
    endfunction

    always_comb begin : group_level
        for (int g = 0; g < 8; g++) begin
            grp_nz[7 - g] = |data_in[63 - 8 * g -: 8];
            grp_cnt[g]    = lzc8(data_in[63 - 8 * g -: 8]);
        end
    end

    always_comb begin : select_level
        grp_sel = lzc8(grp_nz);  // same byte count picks the first nonzero group
        lzc     = {grp_sel, grp_cnt[grp_sel]};
        valid   = |grp_nz;
    end

endmodule

`default_nettype wire

// ==== hdl/fpu_extract.sv ====
// unpacks one single or double operand into the 65-bit extended form
// subnormals come out normalized and a one-hot class mask is produced
// purely combinational, its outputs are registered by the top level

`timescale 1ns/1ns
`default_nettype none

module fpu_extract (
    input  wire fpu_types::fpu_ext_in_type fpu_ext_i,
    output fpu_types::fpu_ext_out_type     fpu_ext_o
);

    logic [63:0] data;
    logic        sign;
    logic [63:0] padded;
    logic [5:0]  count;
    logic        lzc_valid;
    logic        exp_zero;
    logic        exp_ones;
    logic        frac_zero;
    logic [64:0] ext;
    logic [9:0]  cls;

    assign data = fpu_ext_i.data;

    always_comb begin : decode_fields
        sign      = 1'b0;
        padded    = '1;
        exp_zero  = 1'b0;
        exp_ones  = 1'b0;
        frac_zero = 1'b0;
        case (fpu_ext_i.fmt)
            fpu_types::fmt_single: begin
                sign      = data[31];
                padded    = {1'b0, data[22:0], 40'hff_ffff_ffff};  // ones below stop the count
                exp_zero  = ~|data[30:23];
                exp_ones  = &data[30:23];
                frac_zero = ~|data[22:0];
            end
            fpu_types::fmt_double: begin
                sign      = data[63];
                padded    = {1'b0, data[51:0], 11'h7ff};
                exp_zero  = ~|data[62:52];
                exp_ones  = &data[62:52];
                frac_zero = ~|data[51:0];
            end
            default: ;
        endcase
    end

    lzc_64 u_lzc (
        .data_in (padded),
        .lzc     (count),
        .valid   (lzc_valid)
    );

    // the leading zero of the pad makes count one more than the fraction's own zeros
    always_comb begin : build_ext
        ext     = '0;
        ext[64] = sign;
        case (fpu_ext_i.fmt)
            fpu_types::fmt_single: begin
                if (exp_ones) begin
                    ext[63:52] = fpu_types::ext_exp_ones;
                    ext[51:29] = data[22:0];
                end else if (!exp_zero) begin
                    ext[63:52] = {4'h0, data[30:23]} + fpu_types::single_exp_offset;
                    ext[51:29] = data[22:0];
                end else if (lzc_valid && !frac_zero) begin
                    ext[63:52] = fpu_types::single_exp_offset + 12'd1 - {6'h0, count};
                    ext[51:29] = data[22:0] << count;  // hidden one shifts out the top
                end
            end
            fpu_types::fmt_double: begin
                if (exp_ones) begin
                    ext[63:52] = fpu_types::ext_exp_ones;
                    ext[51:0]  = data[51:0];
                end else if (!exp_zero) begin
                    ext[63:52] = {1'b0, data[62:52]} + fpu_types::double_exp_offset;
                    ext[51:0]  = data[51:0];
                end else if (lzc_valid && !frac_zero) begin
                    ext[63:52] = fpu_types::double_exp_offset + 12'd1 - {6'h0, count};
                    ext[51:0]  = data[51:0] << count;
                end
            end
            default: ;
        endcase
    end

    always_comb begin : classify
        cls = '0;
        if (exp_ones && !frac_zero) begin
            // top fraction bit marks a quiet NaN in both formats
            if (ext[51]) begin
                cls[fpu_types::class_qnan] = 1'b1;
            end else begin
                cls[fpu_types::class_snan] = 1'b1;
            end
        end else if (exp_ones) begin
            if (sign) begin
                cls[fpu_types::class_neg_inf] = 1'b1;
            end else begin
                cls[fpu_types::class_pos_inf] = 1'b1;
            end
        end else if (exp_zero && frac_zero) begin
            if (sign) begin
                cls[fpu_types::class_neg_zero] = 1'b1;
            end else begin
                cls[fpu_types::class_pos_zero] = 1'b1;
            end
        end else if (exp_zero) begin
            if (sign) begin
                cls[fpu_types::class_neg_subnormal] = 1'b1;
            end else begin
                cls[fpu_types::class_pos_subnormal] = 1'b1;
            end
        end else if (sign) begin
            cls[fpu_types::class_neg_normal] = 1'b1;
        end else begin
            cls[fpu_types::class_pos_normal] = 1'b1;
        end
    end

    assign fpu_ext_o = '{result: ext, classification: cls};

endmodule

`default_nettype wire

// ==== hdl/fpu_compare.sv ====
// classify, compare and min/max on two extracted operands
// result and invalid flag are registered, one cycle from valid to rsp_valid

`timescale 1ns/1ns
`default_nettype none

module fpu_compare (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         valid,
    input  wire fpu_types::fpu_op_type  op,
    input  wire [1:0]                   fmt,
    input  wire fpu_types::fpu_operand_type a,
    input  wire fpu_types::fpu_operand_type b,
    output logic                        rsp_valid,
    output fpu_types::fpu_rsp_type      rsp
);

    logic        a_snan;
    logic        b_snan;
    logic        a_nan;
    logic        b_nan;
    logic        both_zero;
    logic        mag_lt;
    logic        mag_gt;
    logic        a_below;   // sign-magnitude order where -0 sits below +0
    logic        rel_eq;
    logic        rel_lt;
    logic [63:0] canon_nan;
    logic [63:0] min_val;
    logic [63:0] max_val;
    fpu_types::fpu_rsp_type rsp_next;

    assign a_snan = a.ext.classification[fpu_types::class_snan];
    assign b_snan = b.ext.classification[fpu_types::class_snan];
    assign a_nan  = a_snan | a.ext.classification[fpu_types::class_qnan];
    assign b_nan  = b_snan | b.ext.classification[fpu_types::class_qnan];

    assign both_zero = (a.ext.classification[fpu_types::class_neg_zero] |
                        a.ext.classification[fpu_types::class_pos_zero]) &
                       (b.ext.classification[fpu_types::class_neg_zero] |
                        b.ext.classification[fpu_types::class_pos_zero]);

    // exponent and fraction together order as one unsigned magnitude
    assign mag_lt = a.ext.result[63:0] < b.ext.result[63:0];
    assign mag_gt = a.ext.result[63:0] > b.ext.result[63:0];

    always_comb begin : order
        if (a.ext.result[64] != b.ext.result[64]) begin
            a_below = a.ext.result[64];
        end else if (a.ext.result[64]) begin
            a_below = mag_gt;  // larger magnitude is lower among negatives
        end else begin
            a_below = mag_lt;
        end
    end

    assign rel_eq = !(a_nan || b_nan) && (both_zero || a.ext.result == b.ext.result);
    assign rel_lt = !(a_nan || b_nan) && !both_zero && a_below;

    assign canon_nan = (fmt == fpu_types::fmt_single) ? fpu_types::canon_nan_single
                                                       : fpu_types::canon_nan_double;

    always_comb begin : pick_min_max
        if (a_nan && b_nan) begin
            min_val = canon_nan;
            max_val = canon_nan;
        end else if (a_nan) begin
            min_val = b.raw;
            max_val = b.raw;
        end else if (b_nan) begin
            min_val = a.raw;
            max_val = a.raw;
        end else begin
            min_val = a_below ? a.raw : b.raw;
            max_val = a_below ? b.raw : a.raw;
        end
    end

    always_comb begin : select_op
        rsp_next = '0;
        case (op)
            fpu_types::op_fclass: begin
                rsp_next.result = {54'b0, a.ext.classification};
            end
            fpu_types::op_feq: begin
                rsp_next.result  = {63'b0, rel_eq};
                rsp_next.invalid = a_snan | b_snan;
            end
            fpu_types::op_flt: begin
                rsp_next.result  = {63'b0, rel_lt};
                rsp_next.invalid = a_nan | b_nan;  // signaling compare traps on any NaN
            end
            fpu_types::op_fle: begin
                rsp_next.result  = {63'b0, rel_lt | rel_eq};
                rsp_next.invalid = a_nan | b_nan;
            end
            fpu_types::op_fmin: begin
                rsp_next.result  = min_val;
                rsp_next.invalid = a_snan | b_snan;
            end
            fpu_types::op_fmax: begin
                rsp_next.result  = max_val;
                rsp_next.invalid = a_snan | b_snan;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp <= rsp_next;
    end

    // a request in flight during reset never reaches the output
    assert property (@(posedge clk) reset |=> !rsp_valid && !valid);

    assert property (@(posedge clk) disable iff (reset)
        valid |-> op inside {fpu_types::op_fclass, fpu_types::op_feq, fpu_types::op_flt,
                             fpu_types::op_fle, fpu_types::op_fmin, fpu_types::op_fmax});

endmodule

`default_nettype wire

// ==== hdl/fpu_misc_top.sv ====
// top level of the floating-point misc unit
// takes one request per cycle with no back-pressure and answers in order
// request register, operand register and compare register make up the pipeline

`timescale 1ns/1ns
`default_nettype none

module fpu_misc_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     req_valid,
    input  wire fpu_types::fpu_req_type req,
    output logic                    rsp_valid,
    output fpu_types::fpu_rsp_type  rsp
);

    fpu_types::fpu_req_type     req_q;
    logic                       req_valid_q;
    fpu_types::fpu_ext_in_type  ext_in_a;
    fpu_types::fpu_ext_in_type  ext_in_b;
    fpu_types::fpu_ext_out_type ext_out_a;
    fpu_types::fpu_ext_out_type ext_out_b;
    fpu_types::fpu_operand_type opa_q;
    fpu_types::fpu_operand_type opb_q;
    fpu_types::fpu_op_type      op_q;
    logic [1:0]                 fmt_q;
    logic                       s1_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_q <= 1'b0;
            s1_valid    <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
            s1_valid    <= req_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;
    end

    // both operands share the format of the request
    assign ext_in_a = '{data: req_q.a, fmt: req_q.fmt};
    assign ext_in_b = '{data: req_q.b, fmt: req_q.fmt};

    fpu_extract u_extract_a (
        .fpu_ext_i (ext_in_a),
        .fpu_ext_o (ext_out_a)
    );

    fpu_extract u_extract_b (
        .fpu_ext_i (ext_in_b),
        .fpu_ext_o (ext_out_b)
    );

    always_ff @(posedge clk) begin
        opa_q <= '{ext: ext_out_a, raw: req_q.a};
        opb_q <= '{ext: ext_out_b, raw: req_q.b};
        op_q  <= req_q.op;
        fmt_q <= req_q.fmt;
    end

    fpu_compare u_compare (
        .clk       (clk),
        .reset     (reset),
        .valid     (s1_valid),
        .op        (op_q),
        .fmt       (fmt_q),
        .a         (opa_q),
        .b         (opb_q),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // a live operand lands on one class and only a zero keeps a zero extended magnitude
    assert property (@(posedge clk) disable iff (reset)
        s1_valid |-> $onehot(opa_q.ext.classification) &&
                     $onehot(opb_q.ext.classification) &&
                     ((opa_q.ext.result[63:0] == 64'h0) ==
                      (|opa_q.ext.classification[fpu_types::class_pos_zero:
                                                 fpu_types::class_neg_zero])) &&
                     ((opb_q.ext.result[63:0] == 64'h0) ==
                      (|opb_q.ext.classification[fpu_types::class_pos_zero:
                                                 fpu_types::class_neg_zero])));

endmodule

`default_nettype wire

// ==== bench/fpu_ref_model.svh ====
// reference model of the misc FPU operations for the testbench
// decodes the IEEE fields of single and double operands straight from the raw bits
// included inside the testbench module

`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

typedef struct packed {
    logic        sign;
    logic [62:0] mag;       // exponent and fraction read as one unsigned number
    logic        exp_zero;
    logic        exp_ones;
    logic        frac_zero;
    logic        quiet;
} ieee_fields_type;

function automatic ieee_fields_type decode_fields(input logic [1:0] fmt, input logic [63:0] x);
    ieee_fields_type f;
    if (fmt == fpu_types::fmt_single) begin
        f.sign      = x[31];
        f.mag       = {32'h0, x[30:0]};
        f.exp_zero  = (x[30:23] == 8'h00);
        f.exp_ones  = (x[30:23] == 8'hff);
        f.frac_zero = (x[22:0] == 23'h0);
        f.quiet     = x[22];
    end else begin
        f.sign      = x[63];
        f.mag       = x[62:0];
        f.exp_zero  = (x[62:52] == 11'h000);
        f.exp_ones  = (x[62:52] == 11'h7ff);
        f.frac_zero = (x[51:0] == 52'h0);
        f.quiet     = x[51];
    end
    return f;
endfunction

function automatic logic [9:0] ref_class(input logic [1:0] fmt, input logic [63:0] x);
    ieee_fields_type f;
    logic [9:0]      mask;
    f    = decode_fields(fmt, x);
    mask = '0;
    if (f.exp_ones && !f.frac_zero && f.quiet) mask[fpu_types::class_qnan] = 1'b1;
    else if (f.exp_ones && !f.frac_zero) mask[fpu_types::class_snan] = 1'b1;
    else if (f.exp_ones && f.sign) mask[fpu_types::class_neg_inf] = 1'b1;
    else if (f.exp_ones) mask[fpu_types::class_pos_inf] = 1'b1;
    else if (f.exp_zero && f.frac_zero && f.sign) mask[fpu_types::class_neg_zero] = 1'b1;
    else if (f.exp_zero && f.frac_zero) mask[fpu_types::class_pos_zero] = 1'b1;
    else if (f.exp_zero && f.sign) mask[fpu_types::class_neg_subnormal] = 1'b1;
    else if (f.exp_zero) mask[fpu_types::class_pos_subnormal] = 1'b1;
    else if (f.sign) mask[fpu_types::class_neg_normal] = 1'b1;
    else mask[fpu_types::class_pos_normal] = 1'b1;
    return mask;
endfunction

// a strictly below b; with signed_zero set, -0 sits below +0
function automatic logic ref_below(input ieee_fields_type fa, input ieee_fields_type fb,
                                   input logic signed_zero);
    if (!signed_zero && fa.mag == 63'h0 && fb.mag == 63'h0) return 1'b0;
    if (fa.sign != fb.sign) return fa.sign;
    if (fa.sign) return fa.mag > fb.mag;
    return fa.mag < fb.mag;
endfunction

function automatic fpu_types::fpu_rsp_type ref_response(input fpu_types::fpu_op_type op,
        input logic [1:0] fmt, input logic [63:0] a, input logic [63:0] b);
    ieee_fields_type        fa;
    ieee_fields_type        fb;
    logic                   a_nan;
    logic                   b_nan;
    logic                   any_snan;
    logic                   eq;
    logic                   lt;
    fpu_types::fpu_rsp_type r;
    fa       = decode_fields(fmt, a);
    fb       = decode_fields(fmt, b);
    a_nan    = fa.exp_ones && !fa.frac_zero;
    b_nan    = fb.exp_ones && !fb.frac_zero;
    any_snan = (a_nan && !fa.quiet) || (b_nan && !fb.quiet);
    eq = !(a_nan || b_nan) && ((fa.mag == 63'h0 && fb.mag == 63'h0) ||
                               (fa.sign == fb.sign && fa.mag == fb.mag));
    lt = !(a_nan || b_nan) && ref_below(fa, fb, 1'b0);
    r  = '0;
    case (op)
        fpu_types::op_fclass: r.result = {54'h0, ref_class(fmt, a)};
        fpu_types::op_feq: begin
            r.result  = {63'h0, eq};
            r.invalid = any_snan;
        end
        fpu_types::op_flt, fpu_types::op_fle: begin
            r.result  = {63'h0, lt || (eq && op == fpu_types::op_fle)};
            r.invalid = a_nan || b_nan;
        end
        default: begin
            r.invalid = any_snan;
            if (a_nan && b_nan) begin
                r.result = (fmt == fpu_types::fmt_single) ? fpu_types::canon_nan_single
                                                          : fpu_types::canon_nan_double;
            end else if (a_nan) r.result = b;
            else if (b_nan) r.result = a;
            else if (ref_below(fa, fb, 1'b1) == (op == fpu_types::op_fmin)) r.result = a;
            else r.result = b;
        end
    endcase
    return r;
endfunction

`endif

// ==== bench/tb_fpu_misc.sv ====
// testbench for the floating-point misc unit
// sends classify, compare and min/max requests and checks each response,
// its latency and its order against the reference model

`timescale 1ns/1ns
`default_nettype none

module tb_fpu_misc;

    `include "fpu_ref_model.svh"

    localparam int unsigned clk_period   = 10;
    localparam int unsigned pipe_latency = 3;   // driving edge to the falling edge showing rsp_valid
    localparam int unsigned n_corner     = 16;
    localparam int unsigned n_pairs      = 2 * n_corner * n_corner;
    localparam int unsigned n_rand       = 300;
    localparam int unsigned n_stream     = 500;
    localparam int unsigned n_requests   = 2 * (n_corner + 32) + 5 * n_pairs + 3 * n_rand +
                                           n_stream + 3;
    localparam int unsigned watchdog_cycles = 4 * n_requests + 200;  // up to 3 idle cycles each

    typedef struct packed {
        fpu_types::fpu_rsp_type rsp;
        logic [31:0]            cycle;
    } pending_type;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    fpu_types::fpu_req_type req;
    logic                   rsp_valid;
    fpu_types::fpu_rsp_type rsp;
    pending_type            pending_q[$];
    int unsigned            cycle;
    int unsigned            errors;
    int unsigned            checks;
    int unsigned            test_errors;
    int unsigned            test_checks;

    fpu_misc_top i_fpu_misc_top (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin : clock_gen
        clk   = 1'b0;
        cycle = 0;
        forever begin
            #(clk_period / 2);
            clk = 1'b1;
            cycle++;
            #(clk_period / 2);
            clk = 1'b0;
        end
    end

    // fraction is given left-aligned as in double; single keeps its top 23 bits
    function automatic logic [63:0] make_value(input logic [1:0] fmt, input logic sign,
                                               input logic [10:0] exp, input logic [51:0] frac);
        if (fmt == fpu_types::fmt_single) return {32'hffff_ffff, sign, exp[7:0], frac[51:29]};
        return {sign, exp, frac};
    endfunction

    function automatic logic [63:0] corner(input logic [1:0] fmt, input int unsigned idx);
        case (idx >> 1)
            0: return make_value(fmt, idx[0], 11'h000, 52'h0);
            1: return make_value(fmt, idx[0], 11'h000, 52'h0_0000_2000_0000);
            2: return make_value(fmt, idx[0], 11'h000, '1);
            3: return make_value(fmt, idx[0], 11'h001, 52'h0);
            4: return make_value(fmt, idx[0], 11'h7fe, '1);
            5: return make_value(fmt, idx[0], 11'h7ff, 52'h0);
            6: return make_value(fmt, idx[0], 11'h7ff, 52'h0_0000_2000_0000);
            default: return make_value(fmt, idx[0], 11'h7ff, 52'h8_0000_0000_0000);
        endcase
    endfunction

    function automatic logic [63:0] make_random(input logic [1:0] fmt, input int unsigned kind);
        logic        sign;
        logic [10:0] exp;
        logic [51:0] frac;
        sign = 1'($urandom());
        exp  = 11'($urandom());
        frac = {20'($urandom()), $urandom()};
        case (kind)
            1: exp = '0;
            2: exp = 11'($urandom_range(fmt == fpu_types::fmt_single ? 254 : 2046, 1));
            3: begin exp = '0; frac = '0; end
            4: begin exp = '1; frac = '0; end
            5: begin exp = '1; frac[29] = 1'b1; end  // lowest single fraction bit keeps it a NaN
            7: exp = 11'($urandom_range(3, 1));
            default: ;
        endcase
        if (kind == 6) return corner(fmt, $urandom_range(n_corner - 1));
        return make_value(fmt, sign, exp, frac);
    endfunction

    function automatic fpu_types::fpu_op_type rand_op();
        return fpu_types::fpu_op_type'(3'($urandom_range(5)));
    endfunction

    task automatic send(input fpu_types::fpu_op_type op, input logic [1:0] fmt,
                        input logic [63:0] a, input logic [63:0] b);
        @(negedge clk);
        req_valid = 1'b1;
        req       = '{op: op, fmt: fmt, a: a, b: b};
        pending_q.push_back('{rsp: ref_response(op, fmt, a, b), cycle: cycle});
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic send_corner_pairs(input fpu_types::fpu_op_type op);
        for (int f = 0; f < 2; f++) begin
            for (int unsigned i = 0; i < n_corner; i++) begin
                for (int unsigned j = 0; j < n_corner; j++) begin
                    send(op, 2'(f), corner(2'(f), i), corner(2'(f), j));
                end
            end
        end
    endtask

    task automatic start_test();
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic finish_test(input string name);
        int unsigned waited;
        idle(1);
        waited = 0;
        while (pending_q.size() != 0 && waited < 4 * pipe_latency) begin
            @(negedge clk);
            waited++;
        end
        if (pending_q.size() != 0) begin
            $display("%0d responses of test %s never arrived", pending_q.size(), name);
            errors += pending_q.size();
            pending_q.delete();
        end
        $display("test %-10s checks %0d errors %0d", name, checks - test_checks,
                 errors - test_errors);
    endtask

    always @(negedge clk) begin : compare_responses
        pending_type entry;
        if (rsp_valid) begin
            if (pending_q.size() == 0) begin
                $display("response at cycle %0d came with no request outstanding", cycle);
                errors++;
            end else begin
                entry = pending_q.pop_front();
                checks++;
                assert (rsp.result === entry.rsp.result) else begin
                    $display("ERR rsp.result expected %h actual %h", entry.rsp.result, rsp.result);
                    errors++;
                end
                assert (rsp.invalid === entry.rsp.invalid) else begin
                    $display("ERR rsp.invalid expected %h actual %h", entry.rsp.invalid,
                             rsp.invalid);
                    errors++;
                end
                assert (cycle - entry.cycle == pipe_latency) else begin
                    $display("response came %0d cycles after its request instead of %0d",
                             cycle - entry.cycle, pipe_latency);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [1:0]  fmt;
        logic [63:0] a;
        void'($urandom(24115));
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test();
        for (int f = 0; f < 2; f++) begin
            for (int unsigned i = 0; i < n_corner; i++) begin
                send(fpu_types::op_fclass, 2'(f), corner(2'(f), i), corner(2'(f), 0));
            end
            for (int i = 0; i < 32; i++) begin
                send(fpu_types::op_fclass, 2'(f), make_random(2'(f), $urandom_range(5)),
                     make_random(2'(f), 0));
            end
        end
        finish_test("classify");

        // subnormals against subnormals, small normals and near neighbours
        start_test();
        for (int i = 0; i < n_rand; i++) begin
            fmt = 2'($urandom_range(1));
            a   = make_random(fmt, 1);
            case ($urandom_range(2))
                0: send(rand_op(), fmt, a, make_random(fmt, 1));
                1: send(rand_op(), fmt, a, make_random(fmt, 7));
                default: send(rand_op(), fmt, a, a ^ (64'd1 << $urandom_range(
                              fmt == fpu_types::fmt_single ? 22 : 51)));
            endcase
        end
        finish_test("subnormal");

        start_test();
        send_corner_pairs(fpu_types::op_feq);
        send_corner_pairs(fpu_types::op_flt);
        send_corner_pairs(fpu_types::op_fle);
        for (int i = 0; i < n_rand; i++) begin
            fmt = 2'($urandom_range(1));
            send(fpu_types::fpu_op_type'(3'($urandom_range(3, 1))), fmt,
                 make_random(fmt, $urandom_range(7)), make_random(fmt, $urandom_range(7)));
        end
        finish_test("relations");

        start_test();
        send_corner_pairs(fpu_types::op_fmin);
        send_corner_pairs(fpu_types::op_fmax);
        for (int i = 0; i < n_rand; i++) begin
            fmt = 2'($urandom_range(1));
            send(fpu_types::fpu_op_type'(3'($urandom_range(5, 4))), fmt,
                 make_random(fmt, $urandom_range(7)), make_random(fmt, $urandom_range(7)));
        end
        finish_test("min_max");

        start_test();
        for (int i = 0; i < n_stream; i++) begin
            fmt = 2'($urandom_range(1));
            send(rand_op(), fmt, make_random(fmt, $urandom_range(7)),
                 make_random(fmt, $urandom_range(7)));
            if ($urandom_range(3) == 0) idle($urandom_range(3, 1));
        end
        finish_test("stream");

        // three requests in flight, the last one sampled together with reset
        start_test();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            req_valid = 1'b1;
            req       = '{op: rand_op(), fmt: fpu_types::fmt_double,
                          a: make_random(fpu_types::fmt_double, 0),
                          b: make_random(fpu_types::fmt_double, 0)};
            if (i == 2) reset = 1'b1;
        end
        idle(1);
        reset = 1'b0;
        idle(3 * pipe_latency);
        finish_test("reset");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fpu_misc.f ====
+incdir+bench
hdl/fpu_types.sv
hdl/lzc_64.sv
hdl/fpu_extract.sv
hdl/fpu_compare.sv
hdl/fpu_misc_top.sv
bench/tb_fpu_misc.sv

// ==== Makefile ====
# Verilator build and run of the floating-point misc unit testbench

VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_fpu_misc
RTL_TOP    := fpu_misc_top
FILELIST   := fpu_misc.f
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
